// ==== arith/arith_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_macros.svh"

module arith_unit (
	input  ex_op_pkg::aluop_e  aluop_i,
	input  ex_data_pkg::word_t opa_i,
	input  ex_data_pkg::word_t opb_i,
	output ex_data_pkg::word_t arith_res_o,
	output logic               ov_o
);

	ex_data_pkg::word_t opb_mux;
	ex_data_pkg::word_t sum;
	ex_data_pkg::word_t scan;
	logic               do_sub;
	logic               sum_ov;
	logic               a_lt_b;
	logic [5:0]         lead_cnt;

	//////////////////////////////////////////////////
	// shared adder
	//////////////////////////////////////////////////
	assign do_sub = (aluop_i == ex_op_pkg::OP_SUB) || (aluop_i == ex_op_pkg::OP_SUBU)
		|| (aluop_i == ex_op_pkg::OP_SLT);
	assign opb_mux = do_sub ? (~opb_i + 1'b1) : opb_i;
	assign sum = opa_i + opb_mux;

	// a and the effective sign of b agree but the sum sign does not
	assign sum_ov = (opa_i[`EX_WORD_W-1] == (opb_i[`EX_WORD_W-1] ^ do_sub))
		&& (sum[`EX_WORD_W-1] != opa_i[`EX_WORD_W-1]);

	// only the trapping forms report overflow
	assign ov_o = sum_ov && ((aluop_i == ex_op_pkg::OP_ADD) || (aluop_i == ex_op_pkg::OP_SUB));

	// signed compare uses the sign of the difference
	always_comb begin
		if (aluop_i == ex_op_pkg::OP_SLT) begin
			a_lt_b = (opa_i[`EX_WORD_W-1] && !opb_i[`EX_WORD_W-1])
				|| ((opa_i[`EX_WORD_W-1] == opb_i[`EX_WORD_W-1]) && sum[`EX_WORD_W-1]);
		end else begin
			a_lt_b = opa_i < opb_i;
		end
	end

	//////////////////////////////////////////////////
	// leading zero / one count
	//////////////////////////////////////////////////
	assign scan = (aluop_i == ex_op_pkg::OP_CLO) ? ~opa_i : opa_i;

	// highest set bit wins and 32 means none set
	always_comb begin
		lead_cnt = 6'd32;
		for (int i = 0; i < `EX_WORD_W; i++) begin
			if (scan[i])
				lead_cnt = 6'(`EX_WORD_W - 1 - i);
		end
	end

	always_comb begin
		case (aluop_i)
			ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU,
			ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU: arith_res_o = sum;
			ex_op_pkg::OP_SLT, ex_op_pkg::OP_SLTU: arith_res_o = {{(`EX_WORD_W-1){1'b0}}, a_lt_b};
			ex_op_pkg::OP_CLZ, ex_op_pkg::OP_CLO:  arith_res_o = {{(`EX_WORD_W-6){1'b0}}, lead_cnt};
			default:                               arith_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== arith/mul_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_macros.svh"

module mul_unit (
	input  ex_op_pkg::aluop_e   aluop_i,
	input  ex_data_pkg::word_t  opa_i,
	input  ex_data_pkg::word_t  opb_i,
	output ex_data_pkg::dword_t product_o
);

	ex_data_pkg::word_t  mag_a;
	ex_data_pkg::word_t  mag_b;
	ex_data_pkg::dword_t raw_prod;
	logic                is_signed;
	logic                neg_res;

	// multu takes the operands as they are
	assign is_signed = (aluop_i == ex_op_pkg::OP_MUL) || (aluop_i == ex_op_pkg::OP_MULT);

	// magnitudes of negative signed operands
	assign mag_a = (is_signed && opa_i[`EX_WORD_W-1]) ? (~opa_i + 1'b1) : opa_i;
	assign mag_b = (is_signed && opb_i[`EX_WORD_W-1]) ? (~opb_i + 1'b1) : opb_i;

	assign raw_prod = ex_data_pkg::dword_t'(mag_a) * ex_data_pkg::dword_t'(mag_b);

	// fix the sign afterwards
	assign neg_res = is_signed && (opa_i[`EX_WORD_W-1] ^ opb_i[`EX_WORD_W-1]);
	assign product_o = neg_res ? (~raw_prod + 1'b1) : raw_prod;

endmodule

`default_nettype wire

// ==== common/ex_data_pkg.sv ====
`default_nettype none

`include "ex_macros.svh"

package ex_data_pkg;

	// one data word
	typedef logic [`EX_WORD_W-1:0] word_t;

	// full product, also the hi:lo pair
	typedef logic [2*`EX_WORD_W-1:0] dword_t;

	// destination register index
	typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

	// shift count
	typedef logic [`EX_SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

// ==== common/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////////////////////////
// execute stage widths
//////////////////////////////////////////////////

// data word
`define EX_WORD_W 32

// destination register index
`define EX_REG_ADDR_W 5

// shift count, low bits of operand a
`define EX_SHAMT_W 5

// operation code
`define EX_ALUOP_W 6

`endif

// ==== common/ex_op_pkg.sv ====
`default_nettype none

`include "ex_macros.svh"

package ex_op_pkg;

	//////////////////////////////////////////////////
	// operation codes seen by the execute stage
	//////////////////////////////////////////////////
	typedef enum logic [`EX_ALUOP_W-1:0] {
		OP_NOP = '0,
		// logic
		OP_OR,
		OP_AND,
		OP_NOR,
		OP_XOR,
		// shifts
		OP_SLL,
		OP_SRL,
		OP_SRA,
		// arithmetic and compare
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_SUBU,
		OP_SLT,
		OP_SLTU,
		// leading counts
		OP_CLZ,
		OP_CLO,
		// multiply
		OP_MUL,
		OP_MULT,
		OP_MULTU,
		// hi/lo moves
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO
	} aluop_e;

endpackage

`default_nettype wire

// ==== hdl/ex_result_reg.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_macros.svh"

module ex_result_reg (
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    issue_i,
	input  ex_op_pkg::aluop_e      aluop_i,
	input  ex_data_pkg::reg_addr_t wd_i,
	input  wire                    wreg_i,
	input  ex_data_pkg::word_t     logic_res_i,
	input  ex_data_pkg::word_t     shift_res_i,
	input  ex_data_pkg::word_t     arith_res_i,
	input  ex_data_pkg::word_t     move_res_i,
	input  ex_data_pkg::dword_t    product_i,
	input  wire                    ov_i,
	output logic                   result_valid_o,
	output ex_data_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output ex_data_pkg::word_t     wdata_o,
	output logic                   ov_o
);

	ex_data_pkg::word_t result;

	//////////////////////////////////////////////////
	// result group select
	//////////////////////////////////////////////////
	always_comb begin
		case (aluop_i)
			ex_op_pkg::OP_OR, ex_op_pkg::OP_AND,
			ex_op_pkg::OP_NOR, ex_op_pkg::OP_XOR: result = logic_res_i;
			ex_op_pkg::OP_SLL, ex_op_pkg::OP_SRL,
			ex_op_pkg::OP_SRA: result = shift_res_i;
			ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU,
			ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU,
			ex_op_pkg::OP_SLT, ex_op_pkg::OP_SLTU,
			ex_op_pkg::OP_CLZ, ex_op_pkg::OP_CLO: result = arith_res_i;
			// low word only
			ex_op_pkg::OP_MUL: result = product_i[`EX_WORD_W-1:0];
			ex_op_pkg::OP_MFHI, ex_op_pkg::OP_MFLO: result = move_res_i;
			// hi/lo writers and nop return nothing
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			result_valid_o <= 1'b0;
			wd_o           <= '0;
			wreg_o         <= 1'b0;
			wdata_o        <= '0;
			ov_o           <= 1'b0;
		end else begin
			result_valid_o <= issue_i;
			if (issue_i) begin
				wd_o    <= wd_i;
				wdata_o <= result;
				// overflow cancels the write
				wreg_o  <= wreg_i && !ov_i;
				ov_o    <= ov_i;
			end else begin
				wreg_o <= 1'b0;
				ov_o   <= 1'b0;
			end
		end
	end

	a_valid_after_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
		issue_i |=> result_valid_o);

	a_no_valid_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
		!issue_i |=> !result_valid_o);

	a_ov_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		ov_o |-> !wreg_o);

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module ex_stage (
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    issue_i,
	input  ex_op_pkg::aluop_e      aluop_i,
	input  ex_data_pkg::word_t     opa_i,
	input  ex_data_pkg::word_t     opb_i,
	input  ex_data_pkg::reg_addr_t wd_i,
	input  wire                    wreg_i,
	output logic                   result_valid_o,
	output ex_data_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output ex_data_pkg::word_t     wdata_o,
	output logic                   ov_o,
	output ex_data_pkg::word_t     hi_o,
	output ex_data_pkg::word_t     lo_o
);

	ex_data_pkg::word_t  logic_res;
	ex_data_pkg::word_t  shift_res;
	ex_data_pkg::word_t  arith_res;
	ex_data_pkg::word_t  move_res;
	ex_data_pkg::dword_t product;
	logic                ov;

	//////////////////////////////////////////////////
	// combinational units
	//////////////////////////////////////////////////
	logic_shift_unit u_logic_shift (
		.aluop_i     (aluop_i),
		.opa_i       (opa_i),
		.opb_i       (opb_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res)
	);

	arith_unit u_arith (
		.aluop_i     (aluop_i),
		.opa_i       (opa_i),
		.opb_i       (opb_i),
		.arith_res_o (arith_res),
		.ov_o        (ov)
	);

	mul_unit u_mul (
		.aluop_i   (aluop_i),
		.opa_i     (opa_i),
		.opb_i     (opb_i),
		.product_o (product)
	);

	//////////////////////////////////////////////////
	// state
	//////////////////////////////////////////////////
	hilo_regs u_hilo (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.issue_i    (issue_i),
		.aluop_i    (aluop_i),
		.opa_i      (opa_i),
		.product_i  (product),
		.move_res_o (move_res),
		.hi_o       (hi_o),
		.lo_o       (lo_o)
	);

	ex_result_reg u_result (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.issue_i        (issue_i),
		.aluop_i        (aluop_i),
		.wd_i           (wd_i),
		.wreg_i         (wreg_i),
		.logic_res_i    (logic_res),
		.shift_res_i    (shift_res),
		.arith_res_i    (arith_res),
		.move_res_i     (move_res),
		.product_i      (product),
		.ov_i           (ov),
		.result_valid_o (result_valid_o),
		.wd_o           (wd_o),
		.wreg_o         (wreg_o),
		.wdata_o        (wdata_o),
		.ov_o           (ov_o)
	);

endmodule

`default_nettype wire

// ==== hdl/hilo_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

module hilo_regs (
	input  wire                 clk,
	input  wire                 arst_n_i,
	input  wire                 issue_i,
	input  ex_op_pkg::aluop_e   aluop_i,
	input  ex_data_pkg::word_t  opa_i,
	input  ex_data_pkg::dword_t product_i,
	output ex_data_pkg::word_t  move_res_o,
	output ex_data_pkg::word_t  hi_o,
	output ex_data_pkg::word_t  lo_o
);

	ex_data_pkg::word_t hi_q;
	ex_data_pkg::word_t lo_q;

	//////////////////////////////////////////////////
	// hi/lo write
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (issue_i) begin
			case (aluop_i)
				ex_op_pkg::OP_MULT, ex_op_pkg::OP_MULTU: begin
					{hi_q, lo_q} <= product_i;
				end
				ex_op_pkg::OP_MTHI: hi_q <= opa_i;
				ex_op_pkg::OP_MTLO: lo_q <= opa_i;
				default: ;
			endcase
		end
	end

	// reads see the registered value
	always_comb begin
		case (aluop_i)
			ex_op_pkg::OP_MFHI: move_res_o = hi_q;
			ex_op_pkg::OP_MFLO: move_res_o = lo_q;
			default:            move_res_o = '0;
		endcase
	end

	assign hi_o = hi_q;
	assign lo_o = lo_q;

	// idle cycles leave the pair alone
	a_hilo_stable_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
		!issue_i |=> ($stable(hi_q) && $stable(lo_q)));

endmodule

`default_nettype wire

// ==== hdl/logic_shift_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_macros.svh"

module logic_shift_unit (
	input  ex_op_pkg::aluop_e  aluop_i,
	input  ex_data_pkg::word_t opa_i,
	input  ex_data_pkg::word_t opb_i,
	output ex_data_pkg::word_t logic_res_o,
	output ex_data_pkg::word_t shift_res_o
);

	ex_data_pkg::shamt_t shamt;

	// decode puts the shift amount in operand a
	assign shamt = opa_i[`EX_SHAMT_W-1:0];

	// bitwise group
	always_comb begin
		case (aluop_i)
			ex_op_pkg::OP_OR:  logic_res_o = opa_i | opb_i;
			ex_op_pkg::OP_AND: logic_res_o = opa_i & opb_i;
			ex_op_pkg::OP_NOR: logic_res_o = ~(opa_i | opb_i);
			ex_op_pkg::OP_XOR: logic_res_o = opa_i ^ opb_i;
			default:           logic_res_o = '0;
		endcase
	end

	// shift group, b is the value shifted
	always_comb begin
		case (aluop_i)
			ex_op_pkg::OP_SLL: shift_res_o = opb_i << shamt;
			ex_op_pkg::OP_SRL: shift_res_o = opb_i >> shamt;
			// sign bit fills from the left
			ex_op_pkg::OP_SRA: shift_res_o = ex_data_pkg::word_t'($signed(opb_i) >>> shamt);
			default:           shift_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== tb/tb_ex_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_ex_stage;

	// several times the few hundred cycles of the directed tests
	localparam int TIMEOUT_CYCLES = 2000;

	logic                   clk;
	logic                   arst_n_i;
	logic                   issue_i;
	ex_op_pkg::aluop_e      aluop_i;
	ex_data_pkg::word_t     opa_i;
	ex_data_pkg::word_t     opb_i;
	ex_data_pkg::reg_addr_t wd_i;
	logic                   wreg_i;
	logic                   result_valid_o;
	ex_data_pkg::reg_addr_t wd_o;
	logic                   wreg_o;
	ex_data_pkg::word_t     wdata_o;
	logic                   ov_o;
	ex_data_pkg::word_t     hi_o;
	ex_data_pkg::word_t     lo_o;

	int                     err_cnt;
	int                     chk_cnt;
	int                     cycle_cnt = 0;
	logic [31:0]            lfsr_q;
	ex_data_pkg::word_t     model_hi;
	ex_data_pkg::word_t     model_lo;
	ex_data_pkg::reg_addr_t wd_cnt;
	// expected {wd, wreg, ov, wdata, hi, lo} per issued op in issue order
	logic [102:0]           exp_q[$];
	string                  name_q[$];

	ex_stage dut0 (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.issue_i        (issue_i),
		.aluop_i        (aluop_i),
		.opa_i          (opa_i),
		.opb_i          (opb_i),
		.wd_i           (wd_i),
		.wreg_i         (wreg_i),
		.result_valid_o (result_valid_o),
		.wd_o           (wd_o),
		.wreg_o         (wreg_o),
		.wdata_o        (wdata_o),
		.ov_o           (ov_o),
		.hi_o           (hi_o),
		.lo_o           (lo_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// random words and reference model
	//////////////////////////////////////////////////

	// fibonacci form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output ex_data_pkg::word_t w);
		for (int i = 0; i < 32; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			w[i] = lfsr_q[0];
		end
	endtask

	function automatic int lead_count(input ex_data_pkg::word_t v, input logic bit_val);
		int n;
		n = 0;
		while (n < 32 && v[31 - n] == bit_val)
			n++;
		return n;
	endfunction

	function automatic logic [63:0] signed_prod(input ex_data_pkg::word_t a,
		input ex_data_pkg::word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		return sa * sb;
	endfunction

	function automatic ex_data_pkg::word_t model_data(input ex_op_pkg::aluop_e op,
		input ex_data_pkg::word_t a, input ex_data_pkg::word_t b);
		logic [63:0] p;
		p = signed_prod(a, b);
		case (op)
			ex_op_pkg::OP_OR:   return a | b;
			ex_op_pkg::OP_AND:  return a & b;
			ex_op_pkg::OP_NOR:  return ~(a | b);
			ex_op_pkg::OP_XOR:  return a ^ b;
			ex_op_pkg::OP_SLL:  return b << a[4:0];
			ex_op_pkg::OP_SRL:  return b >> a[4:0];
			// logical shift then sign fill of the vacated top bits
			ex_op_pkg::OP_SRA:  return (b >> a[4:0]) | (b[31] ? ~(32'hffffffff >> a[4:0]) : 32'h0);
			ex_op_pkg::OP_ADD, ex_op_pkg::OP_ADDU: return a + b;
			ex_op_pkg::OP_SUB, ex_op_pkg::OP_SUBU: return a - b;
			ex_op_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_op_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ex_op_pkg::OP_CLZ:  return lead_count(a, 1'b0);
			ex_op_pkg::OP_CLO:  return lead_count(a, 1'b1);
			ex_op_pkg::OP_MUL:  return p[31:0];
			ex_op_pkg::OP_MFHI: return model_hi;
			ex_op_pkg::OP_MFLO: return model_lo;
			default:            return '0;
		endcase
	endfunction

	// signed overflow from a 33-bit sign-extended result
	function automatic logic model_ov(input ex_op_pkg::aluop_e op,
		input ex_data_pkg::word_t a, input ex_data_pkg::word_t b);
		logic [32:0] r;
		if (op == ex_op_pkg::OP_ADD)
			r = {a[31], a} + {b[31], b};
		else if (op == ex_op_pkg::OP_SUB)
			r = {a[31], a} - {b[31], b};
		else
			return 1'b0;
		return r[32] ^ r[31];
	endfunction

	//////////////////////////////////////////////////
	// drive and check
	//////////////////////////////////////////////////
	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic issue_op(input string name, input ex_op_pkg::aluop_e op,
		input ex_data_pkg::word_t a, input ex_data_pkg::word_t b, input logic wreg);
		ex_data_pkg::word_t data;
		logic ov;
		data = model_data(op, a, b);
		ov = model_ov(op, a, b);
		case (op)
			ex_op_pkg::OP_MULT:  {model_hi, model_lo} = signed_prod(a, b);
			ex_op_pkg::OP_MULTU: {model_hi, model_lo} = {32'h0, a} * {32'h0, b};
			ex_op_pkg::OP_MTHI:  model_hi = a;
			ex_op_pkg::OP_MTLO:  model_lo = a;
			default: ;
		endcase
		exp_q.push_back({wd_cnt, wreg & ~ov, ov, data, model_hi, model_lo});
		name_q.push_back({name, " ", op.name()});
		@(posedge clk);
		issue_i <= 1'b1;
		aluop_i <= op;
		opa_i   <= a;
		opb_i   <= b;
		wd_i    <= wd_cnt;
		wreg_i  <= wreg;
		wd_cnt++;
	endtask

	task automatic check_front();
		logic [102:0] e;
		string n;
		e = exp_q.pop_front();
		n = name_q.pop_front();
		check({n, " valid"}, 1, result_valid_o);
		check({n, " wd"}, e[102:98], wd_o);
		check({n, " wreg"}, e[97], wreg_o);
		check({n, " ov"}, e[96], ov_o);
		check({n, " wdata"}, e[95:64], wdata_o);
		check({n, " hi"}, e[63:32], hi_o);
		check({n, " lo"}, e[31:0], lo_o);
	endtask

	task automatic run_one(input string name, input ex_op_pkg::aluop_e op,
		input ex_data_pkg::word_t a, input ex_data_pkg::word_t b, input logic wreg);
		issue_op(name, op, a, b, wreg);
		@(posedge clk);
		issue_i <= 1'b0;
		@(negedge clk);
		check_front();
	endtask

	// two issues on consecutive cycles
	task automatic run_two(input string name, input ex_op_pkg::aluop_e op1,
		input ex_data_pkg::word_t a1, input ex_op_pkg::aluop_e op2, input ex_data_pkg::word_t a2);
		issue_op(name, op1, a1, 32'h0, 1'b1);
		issue_op(name, op2, a2, 32'h0, 1'b1);
		@(negedge clk);
		check_front();
		@(posedge clk);
		issue_i <= 1'b0;
		@(negedge clk);
		check_front();
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic test_reset();
		check("reset valid", 0, result_valid_o);
		check("reset wreg", 0, wreg_o);
		check("reset ov", 0, ov_o);
		check("reset wdata", 0, wdata_o);
		check("reset hi", 0, hi_o);
		check("reset lo", 0, lo_o);
		run_one("reset", ex_op_pkg::OP_OR, 32'h1, 32'h2, 1'b1);
		@(negedge clk);
		check("reset valid pulse", 0, result_valid_o);
	endtask

	task automatic test_logic_shift();
		ex_data_pkg::word_t a;
		ex_data_pkg::word_t b;
		for (int i = 0; i < 6; i++) begin
			rand_word(a);
			rand_word(b);
			// OR through SRA are consecutive codes
			for (int k = 0; k < 7; k++)
				run_one("logic_shift", ex_op_pkg::aluop_e'(int'(ex_op_pkg::OP_OR) + k), a, b, 1'b1);
		end
		rand_word(b);
		run_one("shift0", ex_op_pkg::OP_SLL, 32'h0, b, 1'b1);
		run_one("shift31", ex_op_pkg::OP_SLL, 32'h1f, b, 1'b1);
		run_one("shift31", ex_op_pkg::OP_SRL, 32'hffffffff, b, 1'b1);
		run_one("sra_neg", ex_op_pkg::OP_SRA, 32'h1f, 32'h8000f00d, 1'b1);
		run_one("sra_neg", ex_op_pkg::OP_SRA, 32'h4, 32'hf0000000, 1'b1);
	endtask

	task automatic test_arith();
		ex_data_pkg::word_t a;
		ex_data_pkg::word_t b;
		run_one("wrap", ex_op_pkg::OP_ADDU, 32'hffffffff, 32'h2, 1'b1);
		run_one("wrap", ex_op_pkg::OP_SUBU, 32'h0, 32'h1, 1'b1);
		run_one("overflow", ex_op_pkg::OP_ADD, 32'h7fffffff, 32'h1, 1'b1);
		run_one("overflow", ex_op_pkg::OP_SUB, 32'h80000000, 32'h1, 1'b1);
		// subtracting the most negative word
		run_one("overflow", ex_op_pkg::OP_SUB, 32'h0, 32'h80000000, 1'b1);
		run_one("no_ov", ex_op_pkg::OP_SUB, 32'hffffffff, 32'h80000000, 1'b1);
		run_one("no_ov", ex_op_pkg::OP_ADD, 32'h5, 32'hfffffffd, 1'b1);
		run_one("no_ov", ex_op_pkg::OP_SUB, 32'h5, 32'h3, 1'b0);
		run_one("mixed_sign", ex_op_pkg::OP_SLT, 32'hffffffff, 32'h1, 1'b1);
		run_one("mixed_sign", ex_op_pkg::OP_SLTU, 32'hffffffff, 32'h1, 1'b1);
		for (int i = 0; i < 4; i++) begin
			rand_word(a);
			rand_word(b);
			for (int k = 0; k < 6; k++)
				run_one("arith", ex_op_pkg::aluop_e'(int'(ex_op_pkg::OP_ADD) + k), a, b, 1'b1);
		end
	endtask

	task automatic test_lead();
		ex_data_pkg::word_t a;
		run_one("lead", ex_op_pkg::OP_CLZ, 32'h0, 32'h0, 1'b1);
		run_one("lead", ex_op_pkg::OP_CLO, 32'hffffffff, 32'h0, 1'b1);
		run_one("lead", ex_op_pkg::OP_CLZ, 32'h80000000, 32'h0, 1'b1);
		run_one("lead", ex_op_pkg::OP_CLO, 32'h7fffffff, 32'h0, 1'b1);
		run_one("lead", ex_op_pkg::OP_CLZ, 32'hffffffff, 32'h0, 1'b1);
		run_one("lead", ex_op_pkg::OP_CLO, 32'h0, 32'h0, 1'b1);
		for (int i = 0; i < 4; i++) begin
			rand_word(a);
			run_one("lead_rand", ex_op_pkg::OP_CLZ, a >> (i * 7), 32'h0, 1'b1);
			run_one("lead_rand", ex_op_pkg::OP_CLO, ~(a >> (i * 7)), 32'h0, 1'b1);
		end
	endtask

	task automatic test_mul_hilo();
		ex_data_pkg::word_t a;
		ex_data_pkg::word_t b;
		run_one("mult", ex_op_pkg::OP_MULT, 32'hfffffff9, 32'h5, 1'b0);
		run_two("mf", ex_op_pkg::OP_MFHI, 32'h0, ex_op_pkg::OP_MFLO, 32'h0);
		run_one("multu", ex_op_pkg::OP_MULTU, 32'hfffffff9, 32'h5, 1'b0);
		run_two("mf", ex_op_pkg::OP_MFHI, 32'h0, ex_op_pkg::OP_MFLO, 32'h0);
		for (int i = 0; i < 3; i++) begin
			rand_word(a);
			rand_word(b);
			run_one("mult_rand", ex_op_pkg::OP_MULT, a, b, 1'b0);
			run_two("mf", ex_op_pkg::OP_MFLO, 32'h0, ex_op_pkg::OP_MFHI, 32'h0);
			run_one("multu_rand", ex_op_pkg::OP_MULTU, a, b, 1'b0);
			run_two("mf", ex_op_pkg::OP_MFHI, 32'h0, ex_op_pkg::OP_MFLO, 32'h0);
		end
		rand_word(a);
		rand_word(b);
		run_one("mul", ex_op_pkg::OP_MUL, a, b, 1'b1);
		run_one("mthi", ex_op_pkg::OP_MTHI, 32'h12345678, 32'h0, 1'b0);
		run_one("mtlo", ex_op_pkg::OP_MTLO, 32'h9abcdef0, 32'h0, 1'b0);
		run_two("mf", ex_op_pkg::OP_MFHI, 32'h0, ex_op_pkg::OP_MFLO, 32'h0);
	endtask

	initial begin
		clk      = 1'b0;
		arst_n_i = 1'b0;
		issue_i  = 1'b0;
		aluop_i  = ex_op_pkg::OP_NOP;
		opa_i    = '0;
		opb_i    = '0;
		wd_i     = '0;
		wreg_i   = 1'b0;
		err_cnt  = 0;
		chk_cnt  = 0;
		lfsr_q   = 32'hd20f;
		model_hi = '0;
		model_lo = '0;
		wd_cnt   = '0;
		repeat (5) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		test_reset();
		test_logic_shift();
		test_arith();
		test_lead();
		test_mul_hilo();
		$display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/ex_op_pkg.sv
common/ex_data_pkg.sv
hdl/logic_shift_unit.sv
arith/arith_unit.sv
arith/mul_unit.sv
hdl/hilo_regs.sv
hdl/ex_result_reg.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv
